// File: list.f
logic/pgm_ddr_pkg.sv
logic/ddr_loader_latch.sv
logic/ddr_read_arbiter.sv
logic/ddr_bus_mux.sv
logic/pgm_ddr_hub.sv
tb/ddr_mem_model.sv
tb/tb_pgm_ddr_hub.sv

// File: Bender.yml
package:
  name: pgm_ddr_hub

sources:
  - logic/pgm_ddr_pkg.sv
  - logic/ddr_loader_latch.sv
  - logic/ddr_read_arbiter.sv
  - logic/ddr_bus_mux.sv
  - logic/pgm_ddr_hub.sv
  - target: test
    files:
      - tb/ddr_mem_model.sv
      - tb/tb_pgm_ddr_hub.sv

// File: tb/tb_pgm_ddr_hub.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pgm_ddr_hub;

    localparam int clk_period     = 20;
    localparam int reset_cycles   = 16;
    localparam int n_loads        = 32; // Good loader writes that video reads back
    localparam int n_bad          = 8;  // Writes to a foreign ioctl index
    localparam int n_cpu          = 32;
    localparam int n_aud          = 16;
    localparam int n_race         = 8;  // All three clients at once
    localparam int n_mix          = 16; // Random client mixes
    localparam int n_txn          = 2 * (n_loads + n_bad) + n_cpu + n_aud + 3 * (n_race + n_mix);
    localparam int timeout_cycles = reset_cycles + 40 * n_txn;

    logic                                 fixed_50m_clk;
    logic                                 reset;
    logic                                 ioctl_download;
    logic                                 ioctl_wr;
    logic [pgm_ddr_pkg::ioctl_addr_w-1:0] ioctl_addr;
    logic [15:0]                          ioctl_dout;
    logic [7:0]                           ioctl_index;
    logic                                 ioctl_wait;
    logic                                 cpu_req;
    logic [pgm_ddr_pkg::cpu_addr_w-1:0]   cpu_addr;
    logic                                 cpu_ack;
    logic [15:0]                          cpu_rdata;
    pgm_ddr_pkg::rd_req_t                 vid_req;
    pgm_ddr_pkg::rd_req_t                 aud_req;
    logic                                 vid_ack;
    logic                                 aud_ack;
    logic [pgm_ddr_pkg::ddr_data_w-1:0]   line_data;
    logic                                 ddram_rd;
    logic                                 ddram_we;
    logic [pgm_ddr_pkg::ddr_addr_w-1:0]   ddram_addr;
    logic [pgm_ddr_pkg::ddr_data_w-1:0]   ddram_din;
    logic [pgm_ddr_pkg::ddr_be_w-1:0]     ddram_be;
    logic [pgm_ddr_pkg::ddr_data_w-1:0]   ddram_dout;
    logic                                 ddram_busy;
    logic                                 ddram_dout_ready;

    logic [pgm_ddr_pkg::ddr_data_w-1:0]   shadow [0:255]; // Expected memory contents
    logic [pgm_ddr_pkg::ioctl_addr_w-1:0] load_addr [0:n_loads-1];
    logic [pgm_ddr_pkg::ddr_addr_w-1:0]   pulse_addr;     // Line address of the last read pulse
    logic [2:0]                           ack_seen;       // Acks at the last falling edge
    logic [2:0]                           mix;
    logic [31:0]                          rnd;
    int                                   rd_pulses;      // Pulses since the last completed read
    int                                   total_pulses;
    int                                   total_reads;
    int                                   ack_order [$];  // Client number per ack (cpu 0 video 1 audio 2)
    int unsigned                          seed_val;

    pgm_ddr_hub i_pgm_ddr_hub (.*);

    ddr_mem_model i_ddr_mem_model (.*);

    initial begin
        fixed_50m_clk = 1'b0;
        forever #(clk_period / 2) fixed_50m_clk = ~fixed_50m_clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic check_line(input string name, input logic [pgm_ddr_pkg::ddr_data_w-1:0] exp,
                              input logic [pgm_ddr_pkg::ddr_data_w-1:0] act);
        if (act !== exp) stop_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input logic [pgm_ddr_pkg::ddr_addr_w-1:0] exp,
                              input logic [pgm_ddr_pkg::ddr_addr_w-1:0] act);
        if (act !== exp) stop_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_be(input string name, input logic [pgm_ddr_pkg::ddr_be_w-1:0] exp,
                            input logic [pgm_ddr_pkg::ddr_be_w-1:0] act);
        if (act !== exp) stop_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) stop_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) stop_run($sformatf("Fail %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) stop_run($sformatf("Fail %s: expected %0h, got %0h", name, exp, act));
    endtask

    // Expected line for a line address with the model aliasing on the low 8 bits
    function automatic logic [63:0] ref_line(input logic [pgm_ddr_pkg::ddr_addr_w-1:0] line_addr);
        return shadow[line_addr[7:0]];
    endfunction

    // Expected CPU word from the lane at bits 2:1 with its bytes swapped
    function automatic logic [15:0] ref_cpu_word(input logic [pgm_ddr_pkg::cpu_addr_w-1:0] a);
        logic [63:0] line;
        logic [15:0] word;
        line = shadow[a[10:3]];
        word = line[16 * a[2:1] +: 16];
        return {word[7:0], word[15:8]};
    endfunction

    function automatic logic [pgm_ddr_pkg::ddr_addr_w-1:0] line_of(
        input logic [pgm_ddr_pkg::ioctl_addr_w-1:0] a);
        logic [pgm_ddr_pkg::ddr_addr_w-1:0] l;
        l = '0;
        l[pgm_ddr_pkg::ioctl_addr_w-4:0] = a[pgm_ddr_pkg::ioctl_addr_w-1:3];
        return l;
    endfunction

    function automatic logic [pgm_ddr_pkg::ddr_addr_w-1:0] rand_line();
        logic [31:0] r;
        r = $urandom;
        return r[pgm_ddr_pkg::ddr_addr_w-1:0];
    endfunction

    function automatic logic [pgm_ddr_pkg::cpu_addr_w-1:0] rand_cpu_addr();
        logic [31:0] r;
        r = $urandom;
        return r[pgm_ddr_pkg::cpu_addr_w-1:0];
    endfunction

    // One ioctl word and its stall
    task automatic load_word(input logic [pgm_ddr_pkg::ioctl_addr_w-1:0] a,
                             input logic [15:0] d, input logic [7:0] idx);
        @(posedge fixed_50m_clk);
        ioctl_wr    <= 1'b1;
        ioctl_addr  <= a;
        ioctl_dout  <= d;
        ioctl_index <= idx;
        @(posedge fixed_50m_clk);
        ioctl_wr <= 1'b0;
        @(negedge fixed_50m_clk);
        check_bit("ioctl_wait", idx == pgm_ddr_pkg::rom_index, ioctl_wait);
        while (ioctl_wait) begin
            check_bit("ddram_we", 1'b1, ddram_we); // Write held as long as the stall
            check_addr("ddram_addr", line_of(a), ddram_addr);
            check_be("ddram_be", 8'b11 << (2 * a[2:1]), ddram_be); // Byte pair of the word
            @(negedge fixed_50m_clk);
        end
        check_bit("ddram_we", 1'b0, ddram_we);
        if (idx == pgm_ddr_pkg::rom_index) shadow[a[10:3]][16 * a[2:1] +: 16] = d;
    endtask

    // Raise the enabled requests together and drop each on its ack
    task automatic run_reads(input logic [2:0] en, input logic [pgm_ddr_pkg::cpu_addr_w-1:0] c_a,
                             input logic [pgm_ddr_pkg::ddr_addr_w-1:0] v_a,
                             input logic [pgm_ddr_pkg::ddr_addr_w-1:0] a_a);
        logic [2:0] pending;
        logic [2:0] got;
        pending = en;
        @(posedge fixed_50m_clk);
        cpu_req      <= en[2];
        cpu_addr     <= c_a;
        vid_req.req  <= en[1];
        vid_req.addr <= v_a;
        aud_req.req  <= en[0];
        aud_req.addr <= a_a;
        while (pending != 3'b000) begin
            @(negedge fixed_50m_clk);
            got = pending & {cpu_ack, vid_ack, aud_ack};
            @(posedge fixed_50m_clk);
            if (got[2]) cpu_req <= 1'b0;
            if (got[1]) vid_req.req <= 1'b0;
            if (got[0]) aud_req.req <= 1'b0;
            pending = pending & ~got;
        end
        @(negedge fixed_50m_clk);
        while (cpu_ack || vid_ack || aud_ack) @(negedge fixed_50m_clk);
    endtask

    task automatic log_completion(input int client);
        check_count("ddram_rd pulses per grant", 1, rd_pulses);
        rd_pulses   = 0;
        total_reads = total_reads + 1;
        ack_order.push_back(client);
    endtask

    // Compare process checking each ack on its rising edge
    always @(negedge fixed_50m_clk) begin
        if (reset) begin
            ack_seen  = 3'b000;
            rd_pulses = 0;
        end else begin
            if (ddram_rd && ioctl_download) stop_run("ddram_rd pulsed while the loader owns the port");
            if (ddram_rd) begin
                rd_pulses    = rd_pulses + 1;
                total_pulses = total_pulses + 1;
                pulse_addr   = ddram_addr;
                check_bit("ddram_we", 1'b0, ddram_we);
                check_be("ddram_be", pgm_ddr_pkg::be_read_all, ddram_be); // Reads take the whole line
            end
            if (cpu_ack && !ack_seen[2]) begin
                check_word("cpu_rdata", ref_cpu_word(cpu_addr), cpu_rdata);
                check_addr("ddram_addr (cpu)", pgm_ddr_pkg::ddr_addr_w'(cpu_addr / 8),
                           pulse_addr);
                log_completion(0);
            end
            if (vid_ack && !ack_seen[1]) begin
                check_line("line_data (video)", ref_line(vid_req.addr), line_data);
                check_addr("ddram_addr (video)", vid_req.addr, pulse_addr);
                log_completion(1);
            end
            if (aud_ack && !ack_seen[0]) begin
                check_line("line_data (audio)", ref_line(aud_req.addr), line_data);
                check_addr("ddram_addr (audio)", aud_req.addr, pulse_addr);
                log_completion(2);
            end
            ack_seen = {cpu_ack, vid_ack, aud_ack};
        end
    end

    initial begin
        seed_val       = $urandom(32'h4bdf_d140);
        total_pulses   = 0;
        total_reads    = 0;
        reset          = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        ioctl_index    = '0;
        cpu_req        = 1'b0;
        cpu_addr       = '0;
        vid_req        = '0;
        aud_req        = '0;
        repeat (reset_cycles) @(posedge fixed_50m_clk);
        reset <= 1'b0;
        @(negedge fixed_50m_clk);
        check_bit("ddram_rd", 1'b0, ddram_rd);
        check_bit("ddram_we", 1'b0, ddram_we);
        check_bit("ioctl_wait", 1'b0, ioctl_wait);
        check_bit("cpu_ack", 1'b0, cpu_ack);
        check_bit("vid_ack", 1'b0, vid_ack);
        check_bit("aud_ack", 1'b0, aud_ack);
        for (int i = 0; i < 256; i++) begin
            shadow[i] = i_ddr_mem_model.mem[i]; // Start image of the model
        end

        // ROM download followed by video read-back
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b1;
        for (int i = 0; i < n_loads; i++) begin
            rnd          = $urandom;
            load_addr[i] = rnd[pgm_ddr_pkg::ioctl_addr_w-1:0];
            rnd          = $urandom;
            load_word(load_addr[i], rnd[15:0], pgm_ddr_pkg::rom_index);
        end
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b0;
        for (int i = 0; i < n_loads; i++) begin
            run_reads(3'b010, '0, line_of(load_addr[i]), '0);
        end

        // Foreign index must leave memory alone
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b1;
        for (int i = 0; i < n_bad; i++) begin
            rnd          = $urandom;
            load_addr[i] = rnd[pgm_ddr_pkg::ioctl_addr_w-1:0];
            load_word(load_addr[i], rnd[31:16], 8'(1 + $urandom % 255));
        end
        @(posedge fixed_50m_clk);
        ioctl_download <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            check_line($sformatf("mem[%0d]", i), shadow[i], i_ddr_mem_model.mem[i]);
        end
        for (int i = 0; i < n_bad; i++) begin
            run_reads(3'b010, '0, line_of(load_addr[i]), '0);
        end

        for (int i = 0; i < n_cpu; i++) run_reads(3'b100, rand_cpu_addr(), '0, '0);
        for (int i = 0; i < n_aud; i++) run_reads(3'b001, '0, '0, rand_line());

        // Priority order is CPU before video before audio
        for (int i = 0; i < n_race; i++) begin
            ack_order.delete();
            run_reads(3'b111, rand_cpu_addr(), rand_line(), rand_line());
            check_count("ack order size", 3, ack_order.size());
            for (int k = 0; k < 3; k++) begin
                check_count($sformatf("ack order[%0d]", k), k, ack_order[k]);
            end
        end

        for (int i = 0; i < n_mix; i++) begin
            rnd = $urandom;
            mix = (rnd[2:0] == 3'b000) ? 3'b111 : rnd[2:0];
            run_reads(mix, rand_cpu_addr(), rand_line(), rand_line());
        end

        check_count("completed reads", total_pulses, total_reads);
        $display("test passed");
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period);
        stop_run("Watchdog expired before all transactions completed");
    end

endmodule

`default_nettype wire

// File: tb/ddr_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_mem_model (
    input  wire logic                               fixed_50m_clk,
    input  wire logic                               reset,
    input  wire logic                               ddram_rd,
    input  wire logic                               ddram_we,
    input  wire logic [pgm_ddr_pkg::ddr_addr_w-1:0] ddram_addr,
    input  wire logic [pgm_ddr_pkg::ddr_data_w-1:0] ddram_din,
    input  wire logic [pgm_ddr_pkg::ddr_be_w-1:0]   ddram_be,
    output logic [pgm_ddr_pkg::ddr_data_w-1:0]      ddram_dout,
    output logic                                    ddram_busy,
    output logic                                    ddram_dout_ready
);

    logic [pgm_ddr_pkg::ddr_data_w-1:0] mem [0:255]; // Indexed by the low line address bits
    logic [7:0]                         rd_line;     // Line of the read in flight
    logic [3:0]                         rd_wait;     // Cycles left until data returns

    // Start pattern, every byte depends on the full index
    function automatic logic [63:0] fill_line(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h3c, idx + 8'd17,
                {idx[3:0], idx[7:4]}, idx ^ 8'hc3, 8'h5a - idx, idx * 8'd7};
    endfunction

    // Byte-lane merge of a write into a line
    function automatic logic [63:0] merge_line(input logic [63:0] old_line,
                                               input logic [63:0] new_data,
                                               input logic [7:0] be);
        logic [63:0] res;
        res = old_line;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) res[8*b +: 8] = new_data[8*b +: 8];
        end
        return res;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_line(8'(i));
        end
        ddram_dout       = '0;
        ddram_busy       = 1'b0;
        ddram_dout_ready = 1'b0;
        rd_wait          = '0;
    end

    always @(posedge fixed_50m_clk) begin
        if (reset) begin
            ddram_busy       <= 1'b0;
            ddram_dout_ready <= 1'b0;
            rd_wait          <= '0;
        end else begin
            ddram_busy       <= ($urandom % 4) == 0; // Busy about a quarter of the time
            ddram_dout_ready <= 1'b0;
            if (ddram_we && !ddram_busy) begin
                mem[ddram_addr[7:0]] <= merge_line(mem[ddram_addr[7:0]], ddram_din, ddram_be);
            end
            if (ddram_rd && !ddram_busy) begin
                rd_line <= ddram_addr[7:0];
                rd_wait <= 4'(1 + $urandom % 8); // Latency of 1 to 8 cycles
            end else if (rd_wait != 0) begin
                rd_wait <= rd_wait - 4'd1;
                if (rd_wait == 4'd1) begin
                    ddram_dout_ready <= 1'b1;
                    ddram_dout       <= mem[rd_line];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pgm_ddr_hub.sv
`timescale 1ns/1ns
`default_nettype none

module pgm_ddr_hub (
    input  wire logic                                 fixed_50m_clk,
    input  wire logic                                 reset,
    // ROM loader
    input  wire logic                                 ioctl_download,
    input  wire logic                                 ioctl_wr,
    input  wire logic [pgm_ddr_pkg::ioctl_addr_w-1:0] ioctl_addr,
    input  wire logic [15:0]                          ioctl_dout,
    input  wire logic [7:0]                           ioctl_index,
    output logic                                      ioctl_wait,
    // Main CPU
    input  wire logic                                 cpu_req,
    input  wire logic [pgm_ddr_pkg::cpu_addr_w-1:0]   cpu_addr,
    output logic                                      cpu_ack,
    output logic [15:0]                               cpu_rdata,
    // Video engine and sound chip, shared line output
    input  wire pgm_ddr_pkg::rd_req_t                 vid_req,
    output logic                                      vid_ack,
    input  wire pgm_ddr_pkg::rd_req_t                 aud_req,
    output logic                                      aud_ack,
    output logic [pgm_ddr_pkg::ddr_data_w-1:0]        line_data,
    // DDRAM port
    output logic                                      ddram_rd,
    output logic                                      ddram_we,
    output logic [pgm_ddr_pkg::ddr_addr_w-1:0]        ddram_addr,
    output logic [pgm_ddr_pkg::ddr_data_w-1:0]        ddram_din,
    output logic [pgm_ddr_pkg::ddr_be_w-1:0]          ddram_be,
    input  wire logic [pgm_ddr_pkg::ddr_data_w-1:0]   ddram_dout,
    input  wire logic                                 ddram_busy,
    input  wire logic                                 ddram_dout_ready
);

    pgm_ddr_pkg::ddr_cmd_t ld_cmd;  // Loader write command
    pgm_ddr_pkg::ddr_cmd_t arb_cmd; // Arbiter read command

    // Write path from the loader
    ddr_loader_latch i_ddr_loader_latch (
        .fixed_50m_clk  (fixed_50m_clk),
        .reset          (reset),
        .ioctl_download (ioctl_download),
        .ioctl_wr       (ioctl_wr),
        .ioctl_addr     (ioctl_addr),
        .ioctl_dout     (ioctl_dout),
        .ioctl_index    (ioctl_index),
        .ddram_busy     (ddram_busy),
        .ld_cmd         (ld_cmd),
        .ioctl_wait     (ioctl_wait)
    );

    // Read path for the three clients
    ddr_read_arbiter i_ddr_read_arbiter (
        .fixed_50m_clk    (fixed_50m_clk),
        .reset            (reset),
        .ioctl_download   (ioctl_download),
        .cpu_req          (cpu_req),
        .cpu_addr         (cpu_addr),
        .vid_req          (vid_req),
        .aud_req          (aud_req),
        .ddram_dout       (ddram_dout),
        .ddram_busy       (ddram_busy),
        .ddram_dout_ready (ddram_dout_ready),
        .arb_cmd          (arb_cmd),
        .cpu_ack          (cpu_ack),
        .vid_ack          (vid_ack),
        .aud_ack          (aud_ack),
        .cpu_rdata        (cpu_rdata),
        .line_data        (line_data)
    );

    // One physical port
    ddr_bus_mux i_ddr_bus_mux (
        .ioctl_download (ioctl_download),
        .ld_cmd         (ld_cmd),
        .arb_cmd        (arb_cmd),
        .ddram_busy     (ddram_busy),
        .ddram_rd       (ddram_rd),
        .ddram_we       (ddram_we),
        .ddram_addr     (ddram_addr),
        .ddram_din      (ddram_din),
        .ddram_be       (ddram_be)
    );

endmodule

`default_nettype wire

// File: logic/ddr_bus_mux.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_bus_mux (
    input  wire logic                               ioctl_download,
    input  wire pgm_ddr_pkg::ddr_cmd_t              ld_cmd,
    input  wire pgm_ddr_pkg::ddr_cmd_t              arb_cmd,
    input  wire logic                               ddram_busy,
    output logic                                    ddram_rd,
    output logic                                    ddram_we,
    output logic [pgm_ddr_pkg::ddr_addr_w-1:0]      ddram_addr,
    output logic [pgm_ddr_pkg::ddr_data_w-1:0]      ddram_din,
    output logic [pgm_ddr_pkg::ddr_be_w-1:0]        ddram_be
);

    pgm_ddr_pkg::ddr_cmd_t port_cmd; // Command after selection

    always_comb begin
        // Read side by default, never writes
        port_cmd    = arb_cmd;
        port_cmd.we = 1'b0;
        port_cmd.be = pgm_ddr_pkg::be_read_all;

        // Download hands the whole port to the loader
        if (ioctl_download) begin
            port_cmd = ld_cmd;
        end

        // A read is only valid while the port is free
        port_cmd.rd = port_cmd.rd && !ddram_busy;
    end

    // Write strobe stays up through busy, the controller holds it off
    assign ddram_rd   = port_cmd.rd;
    assign ddram_we   = port_cmd.we;
    assign ddram_addr = port_cmd.addr;
    assign ddram_din  = port_cmd.din;
    assign ddram_be   = port_cmd.be;

endmodule

`default_nettype wire

// File: logic/ddr_read_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_read_arbiter (
    input  wire logic                                 fixed_50m_clk,
    input  wire logic                                 reset,
    input  wire logic                                 ioctl_download,
    // CPU client, byte address
    input  wire logic                                 cpu_req,
    input  wire logic [pgm_ddr_pkg::cpu_addr_w-1:0]   cpu_addr,
    // Line clients
    input  wire pgm_ddr_pkg::rd_req_t                 vid_req,
    input  wire pgm_ddr_pkg::rd_req_t                 aud_req,
    // Port return path
    input  wire logic [pgm_ddr_pkg::ddr_data_w-1:0]   ddram_dout,
    input  wire logic                                 ddram_busy,
    input  wire logic                                 ddram_dout_ready,
    output pgm_ddr_pkg::ddr_cmd_t                     arb_cmd,
    output logic                                      cpu_ack,
    output logic                                      vid_ack,
    output logic                                      aud_ack,
    output logic [15:0]                               cpu_rdata,
    output logic [pgm_ddr_pkg::ddr_data_w-1:0]        line_data
);

    pgm_ddr_pkg::arb_state_t                state;
    logic                                   issued;    // Read pulse already sent
    logic                                   read_done; // Line arrives for current grant
    logic [pgm_ddr_pkg::ddr_data_w-1:0]     line_buf;  // Last captured line
    logic [pgm_ddr_pkg::ddr_addr_w-1:0]     cpu_line;  // CPU byte address as a line
    logic [pgm_ddr_pkg::ddr_addr_w-1:0]     rd_addr;
    logic [15:0]                            cpu_word;

    assign cpu_line = pgm_ddr_pkg::ddr_addr_w'(cpu_addr[pgm_ddr_pkg::cpu_addr_w-1:3]);

    // Ready only counts once the pulse went out
    assign read_done = (state != pgm_ddr_pkg::arb_idle) && issued && ddram_dout_ready;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset) begin
            state   <= pgm_ddr_pkg::arb_idle;
            issued  <= 1'b0;
            cpu_ack <= 1'b0;
            vid_ack <= 1'b0;
            aud_ack <= 1'b0;
        end else begin
            // Ack falls one edge after the client lets go of req
            if (!cpu_req)     cpu_ack <= 1'b0;
            if (!vid_req.req) vid_ack <= 1'b0;
            if (!aud_req.req) aud_ack <= 1'b0;

            if (ioctl_download) begin
                state  <= pgm_ddr_pkg::arb_idle; // Loader owns the port
                issued <= 1'b0;
            end else begin
                case (state)
                    pgm_ddr_pkg::arb_idle: begin
                        issued <= 1'b0;
                        // Fixed priority, a client still holding ack waits its turn
                        if (cpu_req && !cpu_ack) begin
                            state <= pgm_ddr_pkg::arb_cpu;
                        end else if (vid_req.req && !vid_ack) begin
                            state <= pgm_ddr_pkg::arb_video;
                        end else if (aud_req.req && !aud_ack) begin
                            state <= pgm_ddr_pkg::arb_audio;
                        end
                    end

                    default: begin
                        // Pulse goes out in the first non-busy cycle
                        if (!issued && !ddram_busy) issued <= 1'b1;
                        if (read_done) begin
                            state <= pgm_ddr_pkg::arb_idle;
                            case (state)
                                pgm_ddr_pkg::arb_cpu:   cpu_ack <= 1'b1;
                                pgm_ddr_pkg::arb_video: vid_ack <= 1'b1;
                                default:                aud_ack <= 1'b1;
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    // Captured line, kept until the next completed read
    always_ff @(posedge fixed_50m_clk) begin
        if (read_done) line_buf <= ddram_dout;
    end

    // Address of the granted client
    always_comb begin
        case (state)
            pgm_ddr_pkg::arb_cpu:   rd_addr = cpu_line;
            pgm_ddr_pkg::arb_video: rd_addr = vid_req.addr;
            pgm_ddr_pkg::arb_audio: rd_addr = aud_req.addr;
            default:                rd_addr = vid_req.addr; // Don't care while idle
        endcase
    end

    always_comb begin
        arb_cmd      = '0;
        // Busy gating happens on the port side
        arb_cmd.rd   = !ioctl_download && (state != pgm_ddr_pkg::arb_idle) && !issued;
        arb_cmd.we   = 1'b0;
        arb_cmd.addr = rd_addr;
        arb_cmd.din  = '0;
        arb_cmd.be   = pgm_ddr_pkg::be_read_all;
    end

    // Bits 2:1 pick the 16-bit word in the line
    assign cpu_word  = line_buf[{cpu_addr[2:1], 4'b0000} +: 16];
    assign cpu_rdata = {cpu_word[7:0], cpu_word[15:8]}; // 68000 is big endian

    assign line_data = line_buf; // Video and audio take the whole line

endmodule

`default_nettype wire

// File: logic/ddr_loader_latch.sv
`timescale 1ns/1ns
`default_nettype none

module ddr_loader_latch (
    input  wire logic                                 fixed_50m_clk,
    input  wire logic                                 reset,
    input  wire logic                                 ioctl_download,
    input  wire logic                                 ioctl_wr,
    input  wire logic [pgm_ddr_pkg::ioctl_addr_w-1:0] ioctl_addr,
    input  wire logic [15:0]                          ioctl_dout,
    input  wire logic [7:0]                           ioctl_index,
    input  wire logic                                 ddram_busy,
    output pgm_ddr_pkg::ddr_cmd_t                     ld_cmd,
    output logic                                      ioctl_wait
);

    logic                                 wr_pending; // Write waiting for the port
    logic                                 wr_accept;
    logic [pgm_ddr_pkg::ddr_addr_w-1:0]   wr_addr;    // Held line address
    logic [pgm_ddr_pkg::ddr_data_w-1:0]   wr_data;    // Held word, all four lanes
    logic [pgm_ddr_pkg::ddr_be_w-1:0]     wr_be;      // One byte pair enabled

    // New word taken only when the previous one has gone out
    assign wr_accept = ioctl_download && ioctl_wr
                     && (ioctl_index == pgm_ddr_pkg::rom_index)
                     && !wr_pending;

    always_ff @(posedge fixed_50m_clk) begin
        if (reset || !ioctl_download) begin
            wr_pending <= 1'b0; // Leaving download drops any stale write
        end else if (wr_accept) begin
            wr_pending <= 1'b1;
        end else if (wr_pending && !ddram_busy) begin
            wr_pending <= 1'b0; // Port took it on this edge
        end
    end

    // Payload only, control lives above
    always_ff @(posedge fixed_50m_clk) begin
        if (wr_accept) begin
            wr_addr <= pgm_ddr_pkg::ddr_addr_w'(ioctl_addr[pgm_ddr_pkg::ioctl_addr_w-1:3]);
            wr_data <= {4{ioctl_dout}};
            // Bits 2:1 pick the 16-bit lane inside the line
            wr_be   <= pgm_ddr_pkg::ddr_be_w'(2'b11) << {ioctl_addr[2:1], 1'b0};
        end
    end

    always_comb begin
        ld_cmd      = '0;
        ld_cmd.rd   = 1'b0;       // Loader never reads
        ld_cmd.we   = wr_pending;
        ld_cmd.addr = wr_addr;
        ld_cmd.din  = wr_data;
        ld_cmd.be   = wr_be;
    end

    // Stall the loader until the held write is gone
    assign ioctl_wait = wr_pending;

endmodule

`default_nettype wire

// File: logic/pgm_ddr_pkg.sv
`default_nettype none

package pgm_ddr_pkg;

    // DDRAM port geometry
    localparam int ddr_addr_w = 29; // Line address, one line is 8 bytes
    localparam int ddr_data_w = 64; // One full line
    localparam int ddr_be_w   = 8;  // One enable per byte lane

    // Requester address widths
    localparam int cpu_addr_w   = 24; // 68000 byte address
    localparam int ioctl_addr_w = 27; // Loader byte address

    // Only this ioctl target lands in DDRAM
    localparam logic [7:0] rom_index = 8'd0;

    // Reads always fetch the whole line
    localparam logic [ddr_be_w-1:0] be_read_all = '1;

    // One command on the physical port
    typedef struct packed {
        logic                  rd;   // Read strobe
        logic                  we;   // Write strobe
        logic [ddr_addr_w-1:0] addr; // Line address
        logic [ddr_data_w-1:0] din;  // Write data
        logic [ddr_be_w-1:0]   be;   // Byte enables
    } ddr_cmd_t;

    // Read request from a line client
    typedef struct packed {
        logic                  req;  // Held until ack
        logic [ddr_addr_w-1:0] addr; // Line address
    } rd_req_t;

    // Arbiter grant
    // Idle doubles as the state where acks are allowed to drain
    typedef enum logic [1:0] {
        arb_idle,
        arb_cpu,
        arb_video,
        arb_audio
    } arb_state_t;

endpackage

`default_nettype wire
